/* adc_channel.f */
rtl/adc_channel_pkg.sv
rtl/adc_data_format.sv
rtl/adc_dc_filter.sv
rtl/adc_iq_correct.sv
rtl/adc_pn_monitor.sv
rtl/adc_channel_regs.sv
rtl/adc_channel.sv
bench/tb_adc_channel.sv

/* bench/tb_adc_channel.sv */
// adc_channel testbench with clock, reset, stimulus, reference models, assertions and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_adc_channel import adc_channel_pkg::*;;

  localparam int        CHANNEL_ID = 1;
  localparam reg_addr_t OWN_BASE   = reg_addr_t'(CHANNEL_BASE + 16 * CHANNEL_ID);
  localparam reg_addr_t OTHER_BASE = CHANNEL_BASE;
  // sample count over all tests plus a margin for bus ops and drains
  localparam int N_SAMPLES   = 64 + 32 + 64 + 64 + 40 + 2;
  localparam int WATCHDOG_NS = (N_SAMPLES + 40 * 8 + 200) * 8 * 2;

  logic        adc_clk = 1'b0;
  logic        reset;
  raw_sample_t adc_data;
  logic        adc_or;
  logic        adc_valid;
  sample_t     adc_dcfilter_data_in;
  logic        up_wreq;
  reg_addr_t   up_waddr;
  reg_data_t   up_wdata;
  logic        up_rreq;
  reg_addr_t   up_raddr;
  sample_t     adc_dcfilter_data_out;
  logic        adc_dcfilter_valid;
  sample_t     adc_iqcor_data;
  logic        adc_iqcor_valid;
  logic        adc_enable;
  logic        up_wack;
  reg_data_t   up_rdata;
  logic        up_rack;

  // model state
  logic [31:0]        lfsr_state = 32'hd716;
  logic               exp_wack;
  logic               exp_rack;
  reg_data_t          exp_rdata;
  logic               m_enable = 1'b0;
  logic               m_dcen = 1'b0;
  logic               m_iqen = 1'b0;
  logic               m_dfen = 1'b0;
  logic               m_dftype = 1'b0;
  logic               m_dfse = 1'b0;
  sample_t            m_off = '0;
  logic [3:0]         m_shift = '0;
  coeff_t             m_c1 = '0;
  coeff_t             m_c2 = '0;
  pn_sel_t            m_pnsel = '0;
  logic               m_v1;
  logic               m_v2;
  logic               m_v3;
  sample_t            m_fmt;
  sample_t            m_dc;
  sample_t            m_iq;
  logic signed [31:0] m_acc;
  raw_sample_t        pn_last;

  adc_channel #(.CHANNEL_ID(CHANNEL_ID)) adc_channel_inst (.*);

  // 8 ns period
  always #4 adc_clk = ~adc_clk;

  // ****************************************
  // reference models
  // ****************************************

  function automatic logic [31:0] galois_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = galois_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic in_block(reg_addr_t a);
    return a[13:4] == OWN_BASE[13:4];
  endfunction

  function automatic sample_t format_model(raw_sample_t d);
    raw_sample_t v;
    v = d;
    if (!m_dfen)
      return {2'b00, d};
    // offset binary flips the top bit
    if (!m_dftype)
      v[13] = ~v[13];
    return m_dfse ? {{2{v[13]}}, v} : {2'b00, v};
  endfunction

  function automatic sample_t dc_diff_model(sample_t x);
    return x - m_off - sample_t'(m_acc[31:16]);
  endfunction

  function automatic logic signed [31:0] dc_step_model(sample_t d);
    logic signed [31:0] e;
    e = {d, 16'h0000};
    return e >>> m_shift;
  endfunction

  function automatic sample_t iq_model(sample_t a, sample_t b);
    logic signed [47:0] p;
    p = a * m_c1 + b * m_c2;
    p = p >>> 14;
    return p[15:0];
  endfunction

  // next pn word from 14 lfsr steps seeded with the previous word
  function automatic raw_sample_t pn_model_next(raw_sample_t prev, logic pn23);
    logic [22:0] hist;
    logic        fb;
    hist = pn23 ? {prev[8:0], prev} : {9'd0, prev};
    for (int i = 0; i < 14; i++) begin
      fb   = pn23 ? (hist[22] ^ hist[17]) : (hist[8] ^ hist[4]);
      hist = {hist[21:0], fb};
    end
    return hist[13:0];
  endfunction

  function automatic reg_data_t readback(logic [3:0] off);
    case (off)
      REG_CTRL[3:0]:   return {25'd0, m_dfse, m_dftype, m_dfen, 1'b0, m_iqen, m_dcen, m_enable};
      REG_DCFILT[3:0]: return {12'd0, m_shift, m_off};
      REG_IQCOR[3:0]:  return {m_c2, m_c1};
      REG_PNSEL[3:0]:  return {28'd0, m_pnsel};
      default:         return '0;
    endcase
  endfunction

  // cycle model of bus handshake and the three stage datapath
  always @(posedge adc_clk) begin
    if (reset) begin
      exp_wack <= 1'b0;
      exp_rack <= 1'b0;
      m_v1     <= 1'b0;
      m_v2     <= 1'b0;
      m_v3     <= 1'b0;
      m_acc    <= '0;
    end else begin
      exp_wack <= up_wreq && in_block(up_waddr);
      exp_rack <= up_rreq && in_block(up_raddr);
      m_v1     <= adc_valid;
      m_v2     <= m_v1;
      m_v3     <= m_v2;
      if (adc_valid)
        m_fmt <= format_model(adc_data);
      if (m_v1)
        m_dc <= m_dcen ? dc_diff_model(m_fmt) : m_fmt;
      if (!m_dcen)
        m_acc <= '0;
      else if (m_v1)
        m_acc <= m_acc + dc_step_model(dc_diff_model(m_fmt));
      // partner word is sampled with our dc filter valid
      if (m_v2)
        m_iq <= m_iqen ? iq_model(m_dc, adc_dcfilter_data_in) : m_dc;
    end
  end

  // ****************************************
  // checks
  // ****************************************

  task automatic value_error(string name, logic [31:0] got, logic [31:0] exp);
    $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_failed(string what);
    $display("error at t=%0t: %s", $time, what);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  a_reset: assert property (@(posedge adc_clk) reset |=> (!adc_dcfilter_valid &&
      !adc_iqcor_valid && !up_wack && !up_rack && !adc_enable && up_rdata == '0))
    else check_failed("outputs not idle after reset");
  a_wack: assert property (@(posedge adc_clk) disable iff (reset) up_wack == exp_wack)
    else value_error("up_wack", 32'($sampled(up_wack)), 32'($sampled(exp_wack)));
  a_rack: assert property (@(posedge adc_clk) disable iff (reset) up_rack == exp_rack)
    else value_error("up_rack", 32'($sampled(up_rack)), 32'($sampled(exp_rack)));
  a_rdata: assert property (@(posedge adc_clk) disable iff (reset)
      up_rack |-> up_rdata == exp_rdata)
    else value_error("up_rdata", $sampled(up_rdata), $sampled(exp_rdata));
  a_rdata_idle: assert property (@(posedge adc_clk) !up_rack |-> up_rdata == '0)
    else value_error("up_rdata", $sampled(up_rdata), 32'd0);
  a_enable: assert property (@(posedge adc_clk) disable iff (reset) adc_enable == m_enable)
    else value_error("adc_enable", 32'($sampled(adc_enable)), 32'($sampled(m_enable)));
  a_dc_valid: assert property (@(posedge adc_clk) disable iff (reset)
      adc_dcfilter_valid == m_v2)
    else value_error("adc_dcfilter_valid", 32'($sampled(adc_dcfilter_valid)),
                     32'($sampled(m_v2)));
  a_dc_data: assert property (@(posedge adc_clk) disable iff (reset)
      m_v2 |-> adc_dcfilter_data_out == m_dc)
    else value_error("adc_dcfilter_data_out", 32'($sampled(adc_dcfilter_data_out)),
                     32'($sampled(m_dc)));
  a_iq_valid: assert property (@(posedge adc_clk) disable iff (reset)
      adc_iqcor_valid == m_v3)
    else value_error("adc_iqcor_valid", 32'($sampled(adc_iqcor_valid)), 32'($sampled(m_v3)));
  a_iq_data: assert property (@(posedge adc_clk) disable iff (reset)
      m_v3 |-> adc_iqcor_data == m_iq)
    else value_error("adc_iqcor_data", 32'($sampled(adc_iqcor_data)), 32'($sampled(m_iq)));

  // ****************************************
  // bus and stream tasks
  // ****************************************

  // model fields follow the dut from the cycle after the ack
  task automatic write_reg(reg_addr_t addr, reg_data_t data);
    @(posedge adc_clk);
    #1 up_wreq = 1'b1;
    up_waddr = addr;
    up_wdata = data;
    @(posedge adc_clk);
    #1 up_wreq = 1'b0;
    @(posedge adc_clk);
    #1;
    if (in_block(addr)) begin
      case (addr[3:0])
        REG_CTRL[3:0]: begin
          {m_dfse, m_dftype, m_dfen} = data[6:4];
          {m_iqen, m_dcen, m_enable} = data[2:0];
        end
        REG_DCFILT[3:0]: {m_shift, m_off} = data[19:0];
        REG_IQCOR[3:0]:  {m_c2, m_c1} = data;
        REG_PNSEL[3:0]:  m_pnsel = data[3:0];
        default: ;
      endcase
    end
  endtask

  task automatic read_check(reg_addr_t addr, reg_data_t exp);
    @(posedge adc_clk);
    #1 up_rreq = 1'b1;
    up_raddr  = addr;
    exp_rdata = exp;
    @(posedge adc_clk);
    #1 up_rreq = 1'b0;
    @(posedge adc_clk);
    @(posedge adc_clk);
    #1;
  endtask

  task automatic idle_stream();
    @(posedge adc_clk);
    #1 adc_valid = 1'b0;
    adc_or = 1'b0;
    // let the three stages drain
    repeat (4) @(posedge adc_clk);
  endtask

  task automatic send_random(int n);
    for (int i = 0; i < n; i++) begin
      @(posedge adc_clk);
      #1 adc_valid = 1'b1;
      adc_data = raw_sample_t'(rand_bits(14));
      adc_dcfilter_data_in = sample_t'(rand_bits(16));
    end
    idle_stream();
  endtask

  task automatic send_pn(logic pn23, int n);
    for (int i = 0; i < n; i++) begin
      pn_last = pn_model_next(pn_last, pn23);
      @(posedge adc_clk);
      #1 adc_valid = 1'b1;
      adc_data = pn_last;
    end
    idle_stream();
  endtask

  // ****************************************
  // test sequence
  // ****************************************

  initial begin
    reset = 1'b1;
    adc_data = '0;
    adc_or = 1'b0;
    adc_valid = 1'b0;
    adc_dcfilter_data_in = '0;
    up_wreq = 1'b0;
    up_waddr = '0;
    up_wdata = '0;
    up_rreq = 1'b0;
    up_raddr = '0;
    exp_rdata = '0;
    repeat (2) @(posedge adc_clk);
    #1 reset = 1'b0;

    // reset values and bus timing with no ack for channel 0
    read_check(OWN_BASE + REG_STATUS, 32'h2);
    read_check(OWN_BASE + REG_CTRL, 32'h0);
    write_reg(OTHER_BASE + REG_CTRL, 32'h1);
    read_check(OTHER_BASE + REG_CTRL, 32'h0);
    write_reg(OWN_BASE + REG_CTRL, 32'h1);
    read_check(OWN_BASE + REG_CTRL, readback(REG_CTRL[3:0]));

    // pass-through latency
    send_random(64);

    // offset binary with sign extension, then dc removal
    write_reg(OWN_BASE + REG_CTRL, 32'h51);
    read_check(OWN_BASE + REG_CTRL, readback(REG_CTRL[3:0]));
    send_random(32);
    write_reg(OWN_BASE + REG_DCFILT, rand_bits(20));
    read_check(OWN_BASE + REG_DCFILT, readback(REG_DCFILT[3:0]));
    write_reg(OWN_BASE + REG_CTRL, 32'h53);
    send_random(64);

    // i/q correction on top of dc removal
    write_reg(OWN_BASE + REG_IQCOR, rand_bits(32));
    read_check(OWN_BASE + REG_IQCOR, readback(REG_IQCOR[3:0]));
    write_reg(OWN_BASE + REG_CTRL, 32'h57);
    send_random(64);

    // pn9 sync then a bad word sets the sticky error and write 1 clears it
    pn_last = 14'h01ff;
    write_reg(OWN_BASE + REG_PNSEL, 32'(PN_SEL_PN9));
    send_pn(1'b0, 17);
    read_check(OWN_BASE + REG_STATUS, 32'h0);
    pn_last = pn_model_next(pn_last, 1'b0) ^ 14'h0001;
    @(posedge adc_clk);
    #1 adc_valid = 1'b1;
    adc_data = pn_last;
    idle_stream();
    read_check(OWN_BASE + REG_STATUS, 32'h1);
    write_reg(OWN_BASE + REG_STATUS, 32'h1);
    read_check(OWN_BASE + REG_STATUS, 32'h0);

    // monitor off drops sync before pn23
    write_reg(OWN_BASE + REG_PNSEL, 32'hf);
    read_check(OWN_BASE + REG_STATUS, 32'h2);
    write_reg(OWN_BASE + REG_PNSEL, 32'(PN_SEL_PN23));
    read_check(OWN_BASE + REG_PNSEL, readback(REG_PNSEL[3:0]));
    pn_last = 14'h2d5b;
    send_pn(1'b1, 17);
    read_check(OWN_BASE + REG_STATUS, 32'h0);

    // over-range on a valid sample with the monitor off
    write_reg(OWN_BASE + REG_PNSEL, 32'hf);
    @(posedge adc_clk);
    #1 adc_valid = 1'b1;
    adc_or = 1'b1;
    adc_data = raw_sample_t'(rand_bits(14));
    idle_stream();
    read_check(OWN_BASE + REG_STATUS, 32'h6);

    repeat (2) @(posedge adc_clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("error: simulation did not finish within %0d ns", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $fatal(1);
  end

endmodule

`default_nettype wire

/* rtl/adc_channel.sv */
// adc receive channel top: register block, sample datapath and pn monitor
`timescale 1ns/1ns
`default_nettype none

module adc_channel import adc_channel_pkg::*; #(
  parameter int CHANNEL_ID = 0
) (
  input  wire logic        adc_clk,
  input  wire logic        reset,
  input  wire raw_sample_t adc_data,
  input  wire logic        adc_or,
  input  wire logic        adc_valid,
  input  wire sample_t     adc_dcfilter_data_in,
  input  wire logic        up_wreq,
  input  wire reg_addr_t   up_waddr,
  input  wire reg_data_t   up_wdata,
  input  wire logic        up_rreq,
  input  wire reg_addr_t   up_raddr,
  output sample_t          adc_dcfilter_data_out,
  output logic             adc_dcfilter_valid,
  output sample_t          adc_iqcor_data,
  output logic             adc_iqcor_valid,
  output logic             adc_enable,
  output logic             up_wack,
  output reg_data_t        up_rdata,
  output logic             up_rack
);

  // control fields
  logic       dfmt_enable;
  logic       dfmt_type;
  logic       dfmt_se;
  logic       dcfilt_enb;
  sample_t    dcfilt_offset;
  logic [3:0] dcfilt_shift;
  logic       iqcor_enb;
  coeff_t     iqcor_coeff_1;
  coeff_t     iqcor_coeff_2;
  pn_sel_t    pnseq_sel;

  // datapath and monitor
  sample_t    dfmt_data;
  logic       dfmt_valid;
  logic       pn_err;
  logic       pn_oos;

  // ****************************************
  // decode
  // ****************************************

  adc_channel_regs #(.CHANNEL_ID(CHANNEL_ID)) regs_inst (
    .adc_clk       (adc_clk),
    .reset         (reset),
    .up_wreq       (up_wreq),
    .up_waddr      (up_waddr),
    .up_wdata      (up_wdata),
    .up_rreq       (up_rreq),
    .up_raddr      (up_raddr),
    .pn_err        (pn_err),
    .pn_oos        (pn_oos),
    .adc_or        (adc_or),
    .adc_valid     (adc_valid),
    .up_wack       (up_wack),
    .up_rdata      (up_rdata),
    .up_rack       (up_rack),
    .adc_enable    (adc_enable),
    .dfmt_enable   (dfmt_enable),
    .dfmt_type     (dfmt_type),
    .dfmt_se       (dfmt_se),
    .dcfilt_enb    (dcfilt_enb),
    .dcfilt_offset (dcfilt_offset),
    .dcfilt_shift  (dcfilt_shift),
    .iqcor_enb     (iqcor_enb),
    .iqcor_coeff_1 (iqcor_coeff_1),
    .iqcor_coeff_2 (iqcor_coeff_2),
    .pnseq_sel     (pnseq_sel)
  );

  // ****************************************
  // execute, three registered stages
  // ****************************************

  adc_data_format format_inst (
    .adc_clk     (adc_clk),
    .reset       (reset),
    .valid       (adc_valid),
    .data        (adc_data),
    .dfmt_enable (dfmt_enable),
    .dfmt_type   (dfmt_type),
    .dfmt_se     (dfmt_se),
    .valid_out   (dfmt_valid),
    .data_out    (dfmt_data)
  );

  adc_dc_filter dc_filter_inst (
    .adc_clk       (adc_clk),
    .reset         (reset),
    .valid         (dfmt_valid),
    .data          (dfmt_data),
    .dcfilt_enb    (dcfilt_enb),
    .dcfilt_offset (dcfilt_offset),
    .dcfilt_shift  (dcfilt_shift),
    .valid_out     (adc_dcfilter_valid),
    .data_out      (adc_dcfilter_data_out)
  );

  // partner sample arrives alongside our dc filter output
  adc_iq_correct iq_correct_inst (
    .adc_clk       (adc_clk),
    .reset         (reset),
    .valid         (adc_dcfilter_valid),
    .data_in       (adc_dcfilter_data_out),
    .data_iq       (adc_dcfilter_data_in),
    .iqcor_enable  (iqcor_enb),
    .iqcor_coeff_1 (iqcor_coeff_1),
    .iqcor_coeff_2 (iqcor_coeff_2),
    .valid_out     (adc_iqcor_valid),
    .data_out      (adc_iqcor_data)
  );

  // ****************************************
  // result, monitor on the raw stream
  // ****************************************

  adc_pn_monitor pn_monitor_inst (
    .adc_clk   (adc_clk),
    .reset     (reset),
    .valid     (adc_valid),
    .data      (adc_data),
    .pnseq_sel (pnseq_sel),
    .pn_err    (pn_err),
    .pn_oos    (pn_oos)
  );

endmodule

`default_nettype wire

/* rtl/adc_channel_pkg.sv */
// shared widths, register word offsets, channel base address and pn selection codes
`default_nettype none

package adc_channel_pkg;

  // converter and datapath words
  typedef logic        [13:0] raw_sample_t;
  typedef logic signed [15:0] sample_t;
  // i/q coefficient, q1.14
  typedef logic signed [15:0] coeff_t;

  // register bus
  typedef logic [13:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // pn selection, any other code turns monitoring off
  typedef logic [3:0] pn_sel_t;
  localparam pn_sel_t PN_SEL_PN9  = 4'd0;
  localparam pn_sel_t PN_SEL_PN23 = 4'd1;

  // word offsets within a channel block
  localparam reg_addr_t REG_CTRL   = 14'h0000;
  localparam reg_addr_t REG_STATUS = 14'h0001;
  localparam reg_addr_t REG_DCFILT = 14'h0002;
  localparam reg_addr_t REG_IQCOR  = 14'h0003;
  localparam reg_addr_t REG_PNSEL  = 14'h0004;

  // channel n sits at base + 16*n
  localparam reg_addr_t CHANNEL_BASE = 14'h0100;

  // run length that flips the pn sync state
  localparam int PN_SYNC_COUNT = 16;

endpackage

`default_nettype wire

/* rtl/adc_channel_regs.sv */
// channel register block: address decode, control fields, read mux, sticky status
`timescale 1ns/1ns
`default_nettype none

module adc_channel_regs import adc_channel_pkg::*; #(
  parameter int CHANNEL_ID = 0
) (
  input  wire logic      adc_clk,
  input  wire logic      reset,
  input  wire logic      up_wreq,
  input  wire reg_addr_t up_waddr,
  input  wire reg_data_t up_wdata,
  input  wire logic      up_rreq,
  input  wire reg_addr_t up_raddr,
  input  wire logic      pn_err,
  input  wire logic      pn_oos,
  input  wire logic      adc_or,
  input  wire logic      adc_valid,
  output logic           up_wack,
  output reg_data_t      up_rdata,
  output logic           up_rack,
  output logic           adc_enable,
  output logic           dfmt_enable,
  output logic           dfmt_type,
  output logic           dfmt_se,
  output logic           dcfilt_enb,
  output sample_t        dcfilt_offset,
  output logic [3:0]     dcfilt_shift,
  output logic           iqcor_enb,
  output coeff_t         iqcor_coeff_1,
  output coeff_t         iqcor_coeff_2,
  output pn_sel_t        pnseq_sel
);

  localparam reg_addr_t BLOCK_BASE = reg_addr_t'(CHANNEL_BASE + 16 * CHANNEL_ID);

  logic       wr_sel;
  logic       rd_sel;
  logic [3:0] wr_offset;
  reg_data_t  wr_data;
  reg_data_t  rd_word;
  logic       status_wr;
  logic       pn_err_sticky;
  logic       or_sticky;

  // ****************************************
  // decode and handshake
  // ****************************************

  // a block is 16 words, so the upper address bits select the channel
  assign wr_sel = (up_waddr[13:4] == BLOCK_BASE[13:4]);
  assign rd_sel = (up_raddr[13:4] == BLOCK_BASE[13:4]);

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      up_wack  <= 1'b0;
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_wack  <= up_wreq & wr_sel;
      up_rack  <= up_rreq & rd_sel;
      // rdata only carries a value in the ack cycle
      up_rdata <= (up_rreq & rd_sel) ? rd_word : '0;
    end
  end

  // write word held through the ack cycle
  always_ff @(posedge adc_clk) begin
    wr_offset <= up_waddr[3:0];
    wr_data   <= up_wdata;
  end

  // ****************************************
  // control fields
  // ****************************************

  // fields change at the end of the ack cycle
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      adc_enable    <= 1'b0;
      dcfilt_enb    <= 1'b0;
      iqcor_enb     <= 1'b0;
      dfmt_enable   <= 1'b0;
      dfmt_type     <= 1'b0;
      dfmt_se       <= 1'b0;
      dcfilt_offset <= '0;
      dcfilt_shift  <= '0;
      iqcor_coeff_1 <= '0;
      iqcor_coeff_2 <= '0;
      pnseq_sel     <= '0;
    end else if (up_wack) begin
      case (wr_offset)
        REG_CTRL[3:0]: begin
          adc_enable  <= wr_data[0];
          dcfilt_enb  <= wr_data[1];
          iqcor_enb   <= wr_data[2];
          dfmt_enable <= wr_data[4];
          dfmt_type   <= wr_data[5];
          dfmt_se     <= wr_data[6];
        end
        REG_DCFILT[3:0]: begin
          dcfilt_offset <= wr_data[15:0];
          dcfilt_shift  <= wr_data[19:16];
        end
        REG_IQCOR[3:0]: begin
          iqcor_coeff_1 <= wr_data[15:0];
          iqcor_coeff_2 <= wr_data[31:16];
        end
        REG_PNSEL[3:0]: pnseq_sel <= wr_data[3:0];
        default: ;
      endcase
    end
  end

  // ****************************************
  // sticky status
  // ****************************************

  assign status_wr = up_wack && (wr_offset == REG_STATUS[3:0]);

  // a new event wins over a write-one clear in the same cycle
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      pn_err_sticky <= 1'b0;
      or_sticky     <= 1'b0;
    end else begin
      if (pn_err)
        pn_err_sticky <= 1'b1;
      else if (status_wr && wr_data[0])
        pn_err_sticky <= 1'b0;
      if (adc_or && adc_valid)
        or_sticky <= 1'b1;
      else if (status_wr && wr_data[2])
        or_sticky <= 1'b0;
    end
  end

  // read mux, bit 1 of status is the live oos flag
  always_comb begin
    rd_word = '0;
    case (up_raddr[3:0])
      REG_CTRL[3:0]:   rd_word = {25'd0, dfmt_se, dfmt_type, dfmt_enable, 1'b0,
                                  iqcor_enb, dcfilt_enb, adc_enable};
      REG_STATUS[3:0]: rd_word = {29'd0, or_sticky, pn_oos, pn_err_sticky};
      REG_DCFILT[3:0]: rd_word = {12'd0, dcfilt_shift, dcfilt_offset};
      REG_IQCOR[3:0]:  rd_word = {iqcor_coeff_2, iqcor_coeff_1};
      REG_PNSEL[3:0]:  rd_word = {28'd0, pnseq_sel};
      default:         rd_word = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/adc_data_format.sv */
// sample formatting stage: offset-binary to two's complement and sign extension
`timescale 1ns/1ns
`default_nettype none

module adc_data_format import adc_channel_pkg::*; (
  input  wire logic        adc_clk,
  input  wire logic        reset,
  input  wire logic        valid,
  input  wire raw_sample_t data,
  input  wire logic        dfmt_enable,
  input  wire logic        dfmt_type,
  input  wire logic        dfmt_se,
  output logic             valid_out,
  output sample_t          data_out
);

  logic       fmt_msb;
  logic [1:0] fmt_ext;
  sample_t    fmt_data;

  // type 0 is offset binary, flip the msb
  assign fmt_msb  = dfmt_type ? data[13] : ~data[13];
  assign fmt_ext  = dfmt_se ? {2{fmt_msb}} : 2'b00;
  // disabled means plain zero extension
  assign fmt_data = dfmt_enable ? {fmt_ext, fmt_msb, data[12:0]} : {2'b00, data};

  always_ff @(posedge adc_clk) begin
    if (reset)
      valid_out <= 1'b0;
    else
      valid_out <= valid;
  end

  // hold the last word between samples
  always_ff @(posedge adc_clk) begin
    if (valid)
      data_out <= fmt_data;
  end

endmodule

`default_nettype wire

/* rtl/adc_dc_filter.sv */
// dc removal stage: programmed offset and tracked dc estimate subtraction
`timescale 1ns/1ns
`default_nettype none

module adc_dc_filter import adc_channel_pkg::*; (
  input  wire logic       adc_clk,
  input  wire logic       reset,
  input  wire logic       valid,
  input  wire sample_t    data,
  input  wire logic       dcfilt_enb,
  input  wire sample_t    dcfilt_offset,
  input  wire logic [3:0] dcfilt_shift,
  output logic            valid_out,
  output sample_t         data_out
);

  // estimate carries 16 fraction bits below the sample lsb
  logic signed [31:0] dc_acc;
  logic signed [31:0] dc_step;
  sample_t            dc_est;
  sample_t            dc_diff;

  assign dc_est  = dc_acc[31:16];
  // wraps in 16 bits
  assign dc_diff = data - dcfilt_offset - dc_est;
  // loop gain is 2^-shift
  assign dc_step = $signed({dc_diff, 16'h0000}) >>> dcfilt_shift;

  always_ff @(posedge adc_clk) begin
    if (reset)
      valid_out <= 1'b0;
    else
      valid_out <= valid;
  end

  always_ff @(posedge adc_clk) begin
    if (valid)
      data_out <= dcfilt_enb ? dc_diff : data;
  end

  // ****************************************
  // dc tracking
  // ****************************************

  // estimate restarts from zero each time the filter is enabled
  always_ff @(posedge adc_clk) begin
    if (reset)
      dc_acc <= '0;
    else if (!dcfilt_enb)
      dc_acc <= '0;
    else if (valid)
      dc_acc <= dc_acc + dc_step;
  end

endmodule

`default_nettype wire

/* rtl/adc_iq_correct.sv */
// i/q correction stage: two-coefficient product sum with the partner sample
`timescale 1ns/1ns
`default_nettype none

module adc_iq_correct import adc_channel_pkg::*; (
  input  wire logic    adc_clk,
  input  wire logic    reset,
  input  wire logic    valid,
  input  wire sample_t data_in,
  input  wire sample_t data_iq,
  input  wire logic    iqcor_enable,
  input  wire coeff_t  iqcor_coeff_1,
  input  wire coeff_t  iqcor_coeff_2,
  output logic         valid_out,
  output sample_t      data_out
);

  logic signed [31:0] prod_1;
  logic signed [31:0] prod_2;
  // one guard bit for the sum
  logic signed [32:0] prod_sum;

  assign prod_1   = data_in * iqcor_coeff_1;
  assign prod_2   = data_iq * iqcor_coeff_2;
  assign prod_sum = prod_1 + prod_2;

  always_ff @(posedge adc_clk) begin
    if (reset)
      valid_out <= 1'b0;
    else
      valid_out <= valid;
  end

  // q1.14 coefficients, drop 14 fraction bits and keep the low word
  always_ff @(posedge adc_clk) begin
    if (valid)
      data_out <= iqcor_enable ? prod_sum[29:14] : data_in;
  end

endmodule

`default_nettype wire

/* rtl/adc_pn_monitor.sv */
// pn9/pn23 monitor: sample prediction, error flag and sync tracking
`timescale 1ns/1ns
`default_nettype none

module adc_pn_monitor import adc_channel_pkg::*; (
  input  wire logic        adc_clk,
  input  wire logic        reset,
  input  wire logic        valid,
  input  wire raw_sample_t data,
  input  wire pn_sel_t     pnseq_sel,
  output logic             pn_err,
  output logic             pn_oos
);

  typedef enum logic {PN_STATE_OOS, PN_STATE_SYNC} pn_state_t;

  localparam int CNT_W = $clog2(PN_SYNC_COUNT);

  pn_state_t        pn_state;
  logic [CNT_W-1:0] run_cnt;
  raw_sample_t      prev_data;
  raw_sample_t      pn_predict;
  logic             pn_active;
  logic             pn_match;
  logic             run_hit;

  // bit 13 is the oldest bit of a sample, new bits shift in at the lsb
  function automatic raw_sample_t pn_next(raw_sample_t seed, pn_sel_t sel);
    logic [22:0] lfsr;
    logic        fb;
    int          step;
    // pn23 upper history reuses the low bits of the seed
    lfsr = (sel == PN_SEL_PN23) ? {seed[8:0], seed} : {9'd0, seed};
    for (step = 0; step < 14; step++) begin
      fb   = (sel == PN_SEL_PN23) ? (lfsr[22] ^ lfsr[17]) : (lfsr[8] ^ lfsr[4]);
      lfsr = {lfsr[21:0], fb};
    end
    return lfsr[13:0];
  endfunction

  assign pn_active  = (pnseq_sel == PN_SEL_PN9) || (pnseq_sel == PN_SEL_PN23);
  assign pn_predict = pn_next(prev_data, pnseq_sel);
  assign pn_match   = (data == pn_predict);
  // a sample that disagrees with the present state extends the run
  assign run_hit    = (pn_state == PN_STATE_OOS) ? pn_match : ~pn_match;
  assign pn_oos     = (pn_state == PN_STATE_OOS);

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      pn_state  <= PN_STATE_OOS;
      run_cnt   <= '0;
      pn_err    <= 1'b0;
      prev_data <= '0;
    end else begin
      if (valid)
        prev_data <= data;
      if (!pn_active) begin
        pn_state <= PN_STATE_OOS;
        run_cnt  <= '0;
        pn_err   <= 1'b0;
      end else if (valid) begin
        pn_err <= (pn_state == PN_STATE_SYNC) && !pn_match;
        if (!run_hit) begin
          run_cnt <= '0;
        end else if (run_cnt == CNT_W'(PN_SYNC_COUNT - 1)) begin
          // full run, flip between sync and oos
          run_cnt  <= '0;
          pn_state <= (pn_state == PN_STATE_OOS) ? PN_STATE_SYNC : PN_STATE_OOS;
        end else begin
          run_cnt <= run_cnt + 1'b1;
        end
      end else begin
        pn_err <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the adc channel testbench with verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f adc_channel.f \
  --top-module tb_adc_channel -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
